//--- project.f
+incdir+rtl
rtl/tag_cmp_pkg.sv
rtl/sram_req_if.sv
rtl/secded_enc.sv
rtl/secded_dec.sv
rtl/req_select.sv
rtl/line_codec.sv
rtl/tag_hit.sv
rtl/tag_cmp.sv
test/sram_model.sv
test/tb_tag_cmp.sv

//--- run.sh
#!/bin/sh
# compile and run the tag compare testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build && rm -f build/sim.log
verilator --binary --assert --top-module tb_tag_cmp -Mdir build -o sim -f project.f \
  && ./build/sim 2>&1 | tee build/sim.log
grep -q "Everything OK" build/sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- test/tb_tag_cmp.sv
/*
  Tag compare testbench
  full and partial writes, reads, port priority and injected ECC
  errors; concurrent assertions compare the DUT outputs with a line
  model kept in the testbench
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module tb_tag_cmp import tag_cmp_pkg::*; ();

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned NUM_TESTS  = 6;
  localparam int unsigned DEPTH      = 2 ** `TC_INDEX_W;
  localparam cl_be_t BE_FULL  = '{valid: 1'b1, tag: 1'b1, data: 4'b1111};
  localparam cl_be_t BE_HIGH  = '{valid: 1'b0, tag: 1'b0, data: 4'b1100};
  localparam cl_be_t BE_SPLIT = '{valid: 1'b0, tag: 1'b0, data: 4'b0110};

  logic                                      clk_i;
  logic                                      rst_ni;
  logic [`TC_NR_PORTS-1:0][`TC_WAYS-1:0]     req;
  logic [`TC_NR_PORTS-1:0]                   gnt;
  logic [`TC_NR_PORTS-1:0][`TC_INDEX_W-1:0]  addr;
  cache_line_t [`TC_NR_PORTS-1:0]            wdata;
  logic [`TC_NR_PORTS-1:0]                   we;
  cl_be_t [`TC_NR_PORTS-1:0]                 be;
  cache_line_t [`TC_WAYS-1:0]                rdata;
  logic [`TC_NR_PORTS-1:0][`TC_TAG_W-1:0]    late_tag;
  logic [`TC_WAYS-1:0]                       hit_way;
  logic                                      corr;
  logic                                      uncorr;
  logic [`TC_WAYS-1:0]                       sram_req;
  logic                                      sram_we;
  logic [`TC_INDEX_W-1:0]                    sram_addr;
  sram_line_t                                sram_wdata;
  sram_be_t                                  sram_be;
  sram_line_t [`TC_WAYS-1:0]                 sram_rdata;

  // expected values, changed on the falling edge only
  logic                       chk_gnt;
  logic                       chk_rd;
  logic                       chk_hit;
  logic                       chk_err;
  logic [`TC_NR_PORTS-1:0]    exp_gnt;
  cache_line_t [`TC_WAYS-1:0] exp_rd;
  logic [`TC_WAYS-1:0]        exp_hit;
  logic                       exp_corr;
  logic                       exp_uncorr;

  cache_line_t model_mem [`TC_WAYS][DEPTH];
  cache_line_t ln [8];
  logic [31:0] lfsr;
  int unsigned fails;

  tag_cmp tag_cmp_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req), .gnt_o (gnt), .addr_i (addr),
    .wdata_i (wdata), .we_i (we), .be_i (be), .rdata_o (rdata), .tag_i (late_tag),
    .hit_way_o (hit_way), .corr_o (corr), .uncorr_o (uncorr), .sram_req_o (sram_req),
    .sram_we_o (sram_we), .sram_addr_o (sram_addr), .sram_wdata_o (sram_wdata),
    .sram_be_o (sram_be), .sram_rdata_i (sram_rdata)
  );

  sram_model sram_i (
    .clk_i (clk_i), .req_i (sram_req), .we_i (sram_we), .addr_i (sram_addr),
    .wdata_i (sram_wdata), .be_i (sram_be), .rdata_o (sram_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------------
  task automatic mismatch(input string sig, input logic [127:0] exp_v,
                          input logic [127:0] got_v);
    fails++;
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
    $display("Something failed");
    $fatal(1, "check on %s stopped the run", sig);
  endtask

  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_gnt |-> gnt == exp_gnt)
    else mismatch("gnt_o", 128'($sampled(exp_gnt)), 128'($sampled(gnt)));

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_rd |-> rdata == exp_rd)
    else mismatch("rdata_o", 128'($sampled(exp_rd)), 128'($sampled(rdata)));

  a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_hit |-> hit_way == exp_hit)
    else mismatch("hit_way_o", 128'($sampled(exp_hit)), 128'($sampled(hit_way)));

  a_corr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_err |-> corr == exp_corr)
    else mismatch("corr_o", 128'($sampled(exp_corr)), 128'($sampled(corr)));

  a_uncorr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_err |-> uncorr == exp_uncorr)
    else mismatch("uncorr_o", 128'($sampled(exp_uncorr)), 128'($sampled(uncorr)));

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic cache_line_t rand_line();
    cache_line_t l;
    logic [31:0] v;
    v       = rand_bits(`TC_TAG_W);
    l.valid = 1'b1;
    l.tag   = v[`TC_TAG_W-1:0];
    l.data  = rand_bits(`TC_LINE_W);
    return l;
  endfunction

  // a block with some but not all bytes enabled needs a read first
  function automatic logic is_partial(input cl_be_t en);
    int unsigned per_blk;
    int unsigned cnt;
    logic        res;
    per_blk = `TC_BYTES / `TC_BLOCKS;
    res     = 1'b0;
    for (int unsigned b = 0; b < `TC_BLOCKS; b++) begin
      cnt = 0;
      for (int unsigned i = 0; i < per_blk; i++) begin
        cnt += en.data[b * per_blk + i];
      end
      if (cnt != 0 && cnt != per_blk) res = 1'b1;
    end
    return res;
  endfunction

  task automatic apply_write(input int w, input logic [`TC_INDEX_W-1:0] idx,
                             input cache_line_t line, input cl_be_t en);
    if (en.valid) model_mem[w][idx].valid = line.valid;
    if (en.tag) model_mem[w][idx].tag = line.tag;
    for (int i = 0; i < `TC_BYTES; i++) begin
      if (en.data[i]) model_mem[w][idx].data[i*8 +: 8] = line.data[i*8 +: 8];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic idle();
    req      = '0;
    we       = '0;
    late_tag = '0;
    chk_gnt  = 1'b0;
    chk_rd   = 1'b0;
    chk_hit  = 1'b0;
    chk_err  = 1'b0;
  endtask

  task automatic issue_read(input int port, input logic [`TC_INDEX_W-1:0] idx);
    req[port]  = '1;
    addr[port] = idx;
    we[port]   = 1'b0;
  endtask

  // data, hit and flags are due one cycle after the grant
  task automatic expect_read(input int port, input logic [`TC_INDEX_W-1:0] idx,
                             input logic [`TC_TAG_W-1:0] t, input logic data_ok,
                             input logic c, input logic u);
    late_tag[port] = t;
    for (int w = 0; w < `TC_WAYS; w++) begin
      exp_rd[w]  = model_mem[w][idx];
      exp_hit[w] = model_mem[w][idx].valid && (model_mem[w][idx].tag == t);
    end
    chk_rd     = data_ok;
    chk_hit    = 1'b1;
    chk_err    = 1'b1;
    exp_corr   = c;
    exp_uncorr = u;
  endtask

  task automatic read_line(input int port, input logic [`TC_INDEX_W-1:0] idx,
                           input logic [`TC_TAG_W-1:0] t, input logic data_ok,
                           input logic c, input logic u);
    logic [`TC_NR_PORTS-1:0] onehot;
    onehot       = '0;
    onehot[port] = 1'b1;
    idle();
    issue_read(port, idx);
    chk_gnt = 1'b1;
    exp_gnt = onehot;
    next_cycle();
    idle();
    expect_read(port, idx, t, data_ok, c, u);
    chk_gnt = 1'b1;
    exp_gnt = '0;
    next_cycle();
    idle();
  endtask

  task automatic write_line(input int port, input logic [`TC_WAYS-1:0] ways,
                            input logic [`TC_INDEX_W-1:0] idx, input cache_line_t line,
                            input cl_be_t en);
    logic [`TC_NR_PORTS-1:0] onehot;
    logic                    split;
    onehot       = '0;
    onehot[port] = 1'b1;
    split        = is_partial(en);
    idle();
    req[port]   = ways;
    addr[port]  = idx;
    wdata[port] = line;
    we[port]    = 1'b1;
    be[port]    = en;
    chk_gnt     = 1'b1;
    exp_gnt     = split ? '0 : onehot;
    next_cycle();
    // port keeps requesting until the merged write-back is granted
    if (split) begin
      exp_gnt = onehot;
      next_cycle();
    end
    for (int w = 0; w < `TC_WAYS; w++) begin
      if (ways[w]) apply_write(w, idx, line, en);
    end
    idle();
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    lfsr       = 32'h5b7babc3;
    fails      = 0;
    rst_ni     = 1'b0;
    addr       = '0;
    wdata      = '0;
    be         = '0;
    exp_gnt    = '0;
    exp_rd     = '0;
    exp_hit    = '0;
    exp_corr   = 1'b0;
    exp_uncorr = 1'b0;
    idle();
    for (int w = 0; w < `TC_WAYS; w++) begin
      for (int i = 0; i < DEPTH; i++) begin
        model_mem[w][i] = '0;
      end
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // full write then read, one line per way
    ln[0] = rand_line();
    write_line(0, 2'b01, 4'd3, ln[0], BE_FULL);
    read_line(0, 4'd3, ln[0].tag, 1'b1, 1'b0, 1'b0);
    ln[1] = rand_line();
    write_line(1, 2'b10, 4'd5, ln[1], BE_FULL);
    read_line(1, 4'd5, ln[1].tag, 1'b1, 1'b0, 1'b0);

    // both ports at once, port 0 first
    idle();
    issue_read(0, 4'd3);
    issue_read(1, 4'd5);
    chk_gnt = 1'b1;
    exp_gnt = 2'b01;
    next_cycle();
    idle();
    issue_read(1, 4'd5);
    chk_gnt = 1'b1;
    exp_gnt = 2'b10;
    expect_read(0, 4'd3, ln[0].tag, 1'b1, 1'b0, 1'b0);
    next_cycle();
    idle();
    chk_gnt = 1'b1;
    exp_gnt = '0;
    expect_read(1, 4'd5, ln[1].tag, 1'b1, 1'b0, 1'b0);
    next_cycle();
    idle();

    // block-aligned write, then a write that splits both blocks
    ln[2] = rand_line();
    write_line(0, 2'b01, 4'd12, ln[2], BE_FULL);
    ln[3] = rand_line();
    write_line(0, 2'b01, 4'd12, ln[3], BE_HIGH);
    read_line(0, 4'd12, ln[2].tag, 1'b1, 1'b0, 1'b0);
    ln[4] = rand_line();
    write_line(1, 2'b01, 4'd12, ln[4], BE_SPLIT);
    read_line(1, 4'd12, ln[2].tag, 1'b1, 1'b0, 1'b0);

    // sram_line_t bit 30 lies in block 1, bit 50 in the tag codeword
    ln[5] = rand_line();
    write_line(0, 2'b01, 4'd7, ln[5], BE_FULL);
    sram_i.flip_bit(0, 7, 30);
    sram_i.flip_bit(0, 7, 50);
    read_line(0, 4'd7, ln[5].tag, 1'b1, 1'b1, 1'b0);

    // two flips inside block 0
    ln[6] = rand_line();
    write_line(0, 2'b01, 4'd9, ln[6], BE_FULL);
    sram_i.flip_bit(0, 9, 2);
    sram_i.flip_bit(0, 9, 5);
    read_line(0, 4'd9, ln[6].tag, 1'b0, 1'b0, 1'b1);

    // two tag bits off, then a matching tag on an invalid way
    read_line(0, 4'd3, ln[0].tag ^ 10'h201, 1'b1, 1'b0, 1'b0);
    ln[7]       = rand_line();
    ln[7].valid = 1'b0;
    write_line(1, 2'b10, 4'd11, ln[7], BE_FULL);
    read_line(1, 4'd11, ln[7].tag, 1'b1, 1'b0, 1'b0);

    next_cycle();
    if (fails == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "%0d checks failed", fails);
    end
  end

  initial begin
    #(NUM_TESTS * 40 * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * 40);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- test/sram_model.sv
/*
  Tag and data array model
  one entry per way and index, one-cycle read latency, writes only the
  enabled fields and blocks, and lets stored bits be flipped
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module sram_model import tag_cmp_pkg::*; (
  input  logic                      clk_i,
  input  logic [`TC_WAYS-1:0]       req_i,
  input  logic                      we_i,
  input  logic [`TC_INDEX_W-1:0]    addr_i,
  input  sram_line_t                wdata_i,
  input  sram_be_t                  be_i,
  output sram_line_t [`TC_WAYS-1:0] rdata_o
);

  localparam int unsigned DEPTH = 2 ** `TC_INDEX_W;

  sram_line_t mem [`TC_WAYS][DEPTH];

  // all-zero is a clean codeword with the valid bit clear
  initial begin
    for (int w = 0; w < `TC_WAYS; w++) begin
      rdata_o[w] = '0;
      for (int i = 0; i < DEPTH; i++) begin
        mem[w][i] = '0;
      end
    end
  end

  always @(posedge clk_i) begin
    for (int w = 0; w < `TC_WAYS; w++) begin
      if (req_i[w] && we_i) begin
        if (be_i.valid) mem[w][addr_i].valid = wdata_i.valid;
        if (be_i.tag) mem[w][addr_i].tag = wdata_i.tag;
        for (int b = 0; b < `TC_BLOCKS; b++) begin
          if (be_i.data[b]) mem[w][addr_i].data[b] = wdata_i.data[b];
        end
      end else if (req_i[w]) begin
        rdata_o[w] <= mem[w][addr_i];
      end
    end
  end

  // inverts one stored bit of a line
  task automatic flip_bit(input int way, input int idx, input int pos);
    mem[way][idx][pos] = ~mem[way][idx][pos];
  endtask

endmodule

//--- rtl/tag_cmp.sv
/*
  Tag compare stage
  arbitrates the request ports onto SECDED protected tag and data
  arrays and reports per-way hits and ECC errors
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module tag_cmp import tag_cmp_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [`TC_NR_PORTS-1:0][`TC_WAYS-1:0]     req_i,
  output logic [`TC_NR_PORTS-1:0]                   gnt_o,
  input  logic [`TC_NR_PORTS-1:0][`TC_INDEX_W-1:0]  addr_i,
  input  cache_line_t [`TC_NR_PORTS-1:0]            wdata_i,
  input  logic [`TC_NR_PORTS-1:0]                   we_i,
  input  cl_be_t [`TC_NR_PORTS-1:0]                 be_i,
  output cache_line_t [`TC_WAYS-1:0]                rdata_o,
  // late tag, one cycle after the grant
  input  logic [`TC_NR_PORTS-1:0][`TC_TAG_W-1:0]    tag_i,
  output logic [`TC_WAYS-1:0]                       hit_way_o,
  output logic                                      corr_o,
  output logic                                      uncorr_o,
  output logic [`TC_WAYS-1:0]                       sram_req_o,
  output logic                                      sram_we_o,
  output logic [`TC_INDEX_W-1:0]                    sram_addr_o,
  output sram_line_t                                sram_wdata_o,
  output sram_be_t                                  sram_be_o,
  input  sram_line_t [`TC_WAYS-1:0]                 sram_rdata_i
);

  sram_req_if sram_bus ();

  cache_line_t             loaded;
  logic [`TC_NR_PORTS-1:0] id;
  logic [`TC_WAYS-1:0]     way_valid;

  for (genvar w = 0; w < `TC_WAYS; w++) begin : g_valid
    assign way_valid[w] = rdata_o[w].valid;
  end

  req_select req_select_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .loaded_i (loaded),
    .gnt_o    (gnt_o),
    .id_o     (id),
    .bus      (sram_bus.source)
  );

  // in the write-back cycle the issued ways are the buffered ones
  line_codec line_codec_i (
    .bus          (sram_bus.sink),
    .sram_rdata_i (sram_rdata_i),
    .way_sel_i    (sram_bus.req),
    .sram_req_o   (sram_req_o),
    .sram_we_o    (sram_we_o),
    .sram_addr_o  (sram_addr_o),
    .sram_wdata_o (sram_wdata_o),
    .sram_be_o    (sram_be_o),
    .rdata_o      (rdata_o),
    .loaded_o     (loaded),
    .corr_o       (corr_o),
    .uncorr_o     (uncorr_o)
  );

  tag_hit tag_hit_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .tag_i     (tag_i),
    .id_i      (id),
    .stored_i  (sram_rdata_i),
    .valid_i   (way_valid),
    .hit_way_o (hit_way_o)
  );

endmodule

//--- rtl/tag_hit.sv
/*
  Tag hit detection
  encodes the late tag of the granted port and compares it with each
  stored tag codeword, tolerating one differing bit
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module tag_hit import tag_cmp_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`TC_NR_PORTS-1:0][`TC_TAG_W-1:0] tag_i,
  input  logic [`TC_NR_PORTS-1:0]                id_i,
  input  sram_line_t [`TC_WAYS-1:0]              stored_i,
  input  logic [`TC_WAYS-1:0]                    valid_i,
  output logic [`TC_WAYS-1:0]                    hit_way_o
);

  logic [`TC_TAG_W-1:0]                sel_tag;
  logic [`TC_TAG_CW-1:0]               sel_cw;
  logic [`TC_WAYS-1:0][`TC_TAG_CW-1:0] diff;

  always_comb begin
    sel_tag = '0;
    for (int unsigned i = 0; i < `TC_NR_PORTS; i++) begin
      if (id_i[i]) begin
        sel_tag = tag_i[i];
      end
    end
  end

  secded_enc #(.K(`TC_TAG_W)) sel_enc_i (.data_i(sel_tag), .code_o(sel_cw));

  // a single flipped stored bit still counts as a hit
  for (genvar w = 0; w < `TC_WAYS; w++) begin : g_cmp
    assign diff[w]      = sel_cw ^ stored_i[w].tag;
    assign hit_way_o[w] = valid_i[w] && ((diff[w] & (diff[w] - 1'b1)) == '0);
  end

  // after a grant the line can live in one way only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|id_i) |-> $onehot0(hit_way_o))
    else $error("hit_way_o not onehot0: %b", hit_way_o);

endmodule

//--- rtl/line_codec.sv
/*
  Line codec
  encodes the outgoing line, decodes the line of every way and
  combines the error flags of the valid ways
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module line_codec import tag_cmp_pkg::*; (
  sram_req_if.sink                   bus,
  input  sram_line_t [`TC_WAYS-1:0]  sram_rdata_i,
  input  logic [`TC_WAYS-1:0]        way_sel_i,
  output logic [`TC_WAYS-1:0]        sram_req_o,
  output logic                       sram_we_o,
  output logic [`TC_INDEX_W-1:0]     sram_addr_o,
  output sram_line_t                 sram_wdata_o,
  output sram_be_t                   sram_be_o,
  output cache_line_t [`TC_WAYS-1:0] rdata_o,
  output cache_line_t                loaded_o,
  output logic                       corr_o,
  output logic                       uncorr_o
);

  localparam int unsigned BPB = `TC_BYTES / `TC_BLOCKS;

  logic [`TC_BLOCKS-1:0][`TC_BLK_CW-1:0] wblk_cw;
  logic [`TC_TAG_CW-1:0]                 wtag_cw;
  logic [`TC_WAYS-1:0][`TC_TAG_W-1:0]    rtag;
  logic [`TC_WAYS-1:0][`TC_LINE_W-1:0]   rdat;
  // bit TC_BLOCKS holds the tag decoder
  logic [`TC_WAYS-1:0][`TC_BLOCKS:0]     err_c;
  logic [`TC_WAYS-1:0][`TC_BLOCKS:0]     err_u;

  assign sram_req_o  = bus.req;
  assign sram_we_o   = bus.we;
  assign sram_addr_o = bus.addr;

  // write path
  secded_enc #(.K(`TC_TAG_W)) tag_enc_i (.data_i(bus.wline.tag), .code_o(wtag_cw));

  for (genvar b = 0; b < `TC_BLOCKS; b++) begin : g_wblk
    secded_enc #(.K(`TC_BLK_W)) blk_enc_i (
      .data_i (bus.wline.data[b*`TC_BLK_W +: `TC_BLK_W]),
      .code_o (wblk_cw[b])
    );
  end

  always_comb begin
    sram_wdata_o.valid = bus.wline.valid;
    sram_wdata_o.tag   = wtag_cw;
    sram_wdata_o.data  = wblk_cw;
    sram_be_o.valid    = bus.be.valid;
    sram_be_o.tag      = bus.be.tag;
    // a block is written when any of its bytes is
    for (int unsigned b = 0; b < `TC_BLOCKS; b++) begin
      sram_be_o.data[b] = |bus.be.data[b*BPB +: BPB];
    end
  end

  // read path, one decoder per block and tag in every way
  for (genvar w = 0; w < `TC_WAYS; w++) begin : g_way
    secded_dec #(.K(`TC_TAG_W)) tag_dec_i (
      .code_i   (sram_rdata_i[w].tag),
      .data_o   (rtag[w]),
      .corr_o   (err_c[w][`TC_BLOCKS]),
      .uncorr_o (err_u[w][`TC_BLOCKS])
    );
    for (genvar b = 0; b < `TC_BLOCKS; b++) begin : g_rblk
      secded_dec #(.K(`TC_BLK_W)) blk_dec_i (
        .code_i   (sram_rdata_i[w].data[b]),
        .data_o   (rdat[w][b*`TC_BLK_W +: `TC_BLK_W]),
        .corr_o   (err_c[w][b]),
        .uncorr_o (err_u[w][b])
      );
    end
    assign rdata_o[w] = '{valid: sram_rdata_i[w].valid, tag: rtag[w], data: rdat[w]};
  end

  // lowest selected way feeds the merge
  always_comb begin
    loaded_o = '0;
    for (int w = `TC_WAYS - 1; w >= 0; w--) begin
      if (way_sel_i[w]) begin
        loaded_o = rdata_o[w];
      end
    end
  end

  always_comb begin
    corr_o   = 1'b0;
    uncorr_o = 1'b0;
    for (int unsigned w = 0; w < `TC_WAYS; w++) begin
      if (sram_rdata_i[w].valid) begin
        corr_o   |= |err_c[w];
        uncorr_o |= |err_u[w];
      end
    end
  end

endmodule

//--- rtl/req_select.sv
/*
  Request selection
  fixed-priority arbiter over the request ports with a two-state store
  FSM; a write that splits an ECC block is turned into a read followed
  by a merged write-back one cycle later
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

module req_select import tag_cmp_pkg::*; (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [`TC_NR_PORTS-1:0][`TC_WAYS-1:0]     req_i,
  input  logic [`TC_NR_PORTS-1:0][`TC_INDEX_W-1:0]  addr_i,
  input  cache_line_t [`TC_NR_PORTS-1:0]            wdata_i,
  input  logic [`TC_NR_PORTS-1:0]                   we_i,
  input  cl_be_t [`TC_NR_PORTS-1:0]                 be_i,
  input  cache_line_t                               loaded_i,
  output logic [`TC_NR_PORTS-1:0]                   gnt_o,
  output logic [`TC_NR_PORTS-1:0]                   id_o,
  sram_req_if.source                                bus
);

  localparam int unsigned BPB = `TC_BYTES / `TC_BLOCKS;

  typedef enum logic {NORMAL, LOAD_AND_STORE} store_state_e;

  store_state_e                   state_d, state_q;
  logic [`TC_NR_PORTS-1:0]        id_d, id_q;
  logic [`TC_WAYS-1:0]            req_d, req_q;
  logic [`TC_INDEX_W-1:0]         addr_d, addr_q;
  cache_line_t                    line_d, line_q;
  cl_be_t                         be_d, be_q;
  cache_line_t                    merged;

  // true when some block has both set and clear byte enables
  function automatic logic splits_block(logic [`TC_BYTES-1:0] be);
    logic mixed;
    mixed = 1'b0;
    for (int unsigned b = 0; b < `TC_BLOCKS; b++) begin
      mixed |= (|be[b*BPB +: BPB]) && !(&be[b*BPB +: BPB]);
    end
    return mixed;
  endfunction

  // ---------------------------------------------------------------------------
  // byte merge of the buffered write into the line read back
  // ---------------------------------------------------------------------------
  always_comb begin
    merged = loaded_i;
    if (be_q.valid) begin
      merged.valid = line_q.valid;
    end
    if (be_q.tag) begin
      merged.tag = line_q.tag;
    end
    for (int unsigned i = 0; i < `TC_BYTES; i++) begin
      if (be_q.data[i]) begin
        merged.data[i*8 +: 8] = line_q.data[i*8 +: 8];
      end
    end
  end

  // ---------------------------------------------------------------------------
  // arbitration and store FSM
  // ---------------------------------------------------------------------------
  always_comb begin
    logic found;
    found     = 1'b0;
    state_d   = NORMAL;
    gnt_o     = '0;
    id_d      = '0;
    req_d     = req_q;
    addr_d    = addr_q;
    line_d    = line_q;
    be_d      = be_q;
    bus.req   = '0;
    bus.we    = 1'b0;
    bus.addr  = '0;
    bus.be    = '0;
    bus.wline = '0;
    if (state_q == NORMAL) begin
      // lowest port with any way bit wins
      for (int unsigned i = 0; i < `TC_NR_PORTS; i++) begin
        if (!found && (|req_i[i])) begin
          found     = 1'b1;
          gnt_o[i]  = 1'b1;
          id_d[i]   = 1'b1;
          bus.req   = req_i[i];
          bus.we    = we_i[i];
          bus.addr  = addr_i[i];
          bus.be    = be_i[i];
          bus.wline = wdata_i[i];
          req_d     = req_i[i];
          addr_d    = addr_i[i];
          line_d    = wdata_i[i];
          be_d      = be_i[i];
          // read the line first, write it back next cycle
          if (we_i[i] && splits_block(be_i[i].data)) begin
            state_d  = LOAD_AND_STORE;
            bus.we   = 1'b0;
            gnt_o[i] = 1'b0;
          end
        end
      end
    end else begin
      gnt_o     = id_q;
      id_d      = id_q;
      bus.req   = req_q;
      bus.we    = 1'b1;
      bus.addr  = addr_q;
      bus.be    = be_q;
      bus.wline = merged;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= NORMAL;
      id_q    <= '0;
      req_q   <= '0;
      addr_q  <= '0;
      line_q  <= '0;
      be_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
      req_q   <= req_d;
      addr_q  <= addr_d;
      line_q  <= line_d;
      be_q    <= be_d;
    end
  end

  assign id_o = id_q;

  // at most one port granted, also across the write-back cycle
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o))
    else $error("gnt_o not onehot0: %b", gnt_o);

  // write-back slot is a single cycle
  a_las_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == LOAD_AND_STORE |=> state_q == NORMAL)
    else $error("store FSM stayed in LOAD_AND_STORE");

endmodule

//--- rtl/secded_dec.sv
/*
  SECDED decoder
  corrects a single flipped bit and flags a double error as
  uncorrectable
*/
`timescale 1ns/1ps

module secded_dec #(
  parameter  int unsigned K = 16,
  localparam int unsigned R = $clog2(K + $clog2(K) + 1)
) (
  input  logic [K+R:0] code_i,
  output logic [K-1:0] data_o,
  output logic         corr_o,
  output logic         uncorr_o
);

  localparam int unsigned N = K + R;

  logic [N:1]   hc;
  logic [R-1:0] syn;
  logic         par;

  always_comb begin
    int unsigned d;
    hc       = code_i[N-1:0];
    par      = ^code_i;
    syn      = '0;
    corr_o   = 1'b0;
    uncorr_o = 1'b0;
    for (int unsigned j = 0; j < R; j++) begin
      for (int unsigned p = 1; p <= N; p++) begin
        if (((p >> j) & 1) != 0) begin
          syn[j] ^= hc[p];
        end
      end
    end
    // odd weight means one flip, zero syndrome puts it on the parity bit
    if (par) begin
      if (syn == '0) begin
        corr_o = 1'b1;
      end else if (syn <= N) begin
        hc[syn] = ~hc[syn];
        corr_o  = 1'b1;
      end else begin
        uncorr_o = 1'b1;
      end
    end else if (syn != '0) begin
      uncorr_o = 1'b1;
    end
    // gather the data positions back
    data_o = '0;
    d      = 0;
    for (int unsigned p = 1; p <= N; p++) begin
      if ((p & (p - 1)) != 0) begin
        data_o[d] = hc[p];
        d++;
      end
    end
  end

endmodule

//--- rtl/secded_enc.sv
/*
  SECDED encoder
  extended Hamming code over one block: check bits at the power-of-two
  positions, overall parity bit on top
*/
`timescale 1ns/1ps

module secded_enc #(
  parameter  int unsigned K = 16,
  localparam int unsigned R = $clog2(K + $clog2(K) + 1)
) (
  input  logic [K-1:0] data_i,
  output logic [K+R:0] code_o
);

  localparam int unsigned N = K + R;

  // hamming positions 1..N
  logic [N:1] hc;

  always_comb begin
    int unsigned d;
    hc = '0;
    d  = 0;
    // data fills the non-power-of-two positions in order
    for (int unsigned p = 1; p <= N; p++) begin
      if ((p & (p - 1)) != 0) begin
        hc[p] = data_i[d];
        d++;
      end
    end
    // check bit j covers every position with bit j set
    for (int unsigned j = 0; j < R; j++) begin
      for (int unsigned p = 1; p <= N; p++) begin
        if ((((p >> j) & 1) != 0) && (p != (1 << j))) begin
          hc[1 << j] ^= hc[p];
        end
      end
    end
  end

  assign code_o = {^hc, hc};

endmodule

//--- rtl/sram_req_if.sv
/*
  Array request bundle
  one-cycle request from the arbiter to the ECC codec, carrying the
  decoded write line with byte enables
*/
`timescale 1ns/1ps
`include "tag_cmp_cfg.svh"

interface sram_req_if import tag_cmp_pkg::*; ();

  logic [`TC_WAYS-1:0]    req;
  logic                   we;
  logic [`TC_INDEX_W-1:0] addr;
  cl_be_t                 be;
  cache_line_t            wline;

  modport source (output req, we, addr, be, wline);
  modport sink   (input  req, we, addr, be, wline);

endinterface

//--- rtl/tag_cmp_pkg.sv
/*
  Tag compare types
  decoded and encoded cache lines and their write enables
*/
`include "tag_cmp_cfg.svh"

package tag_cmp_pkg;

  // line as seen by the request ports
  typedef struct packed {
    logic                  valid;
    logic [`TC_TAG_W-1:0]  tag;
    logic [`TC_LINE_W-1:0] data;
  } cache_line_t;

  // line as stored in the arrays, valid is kept unencoded
  typedef struct packed {
    logic                                  valid;
    logic [`TC_TAG_CW-1:0]                 tag;
    logic [`TC_BLOCKS-1:0][`TC_BLK_CW-1:0] data;
  } sram_line_t;

  typedef struct packed {
    logic                 valid;
    logic                 tag;
    logic [`TC_BYTES-1:0] data;
  } cl_be_t;

  // one enable per ECC block
  typedef struct packed {
    logic                  valid;
    logic                  tag;
    logic [`TC_BLOCKS-1:0] data;
  } sram_be_t;

endpackage

//--- rtl/tag_cmp_cfg.svh
/*
  Tag compare configuration
  port count, associativity, field widths and SECDED code sizes
*/
`ifndef TAG_CMP_CFG_SVH
`define TAG_CMP_CFG_SVH

`define TC_NR_PORTS 2
`define TC_WAYS     2
`define TC_INDEX_W  4

// tag carries four check bits and one overall parity bit
`define TC_TAG_W    10
`define TC_TAG_CW   15

// data is protected in blocks of two bytes
`define TC_BLK_W    16
`define TC_BLK_CW   22
`define TC_BLOCKS   2
`define TC_LINE_W   32
`define TC_BYTES    4

`endif
